// File: verilog/riscv_pkg.sv
/* trap codes 0..15 carry the mcause code in their low 4 bits; 16 and up are pseudo codes
   only the standard machine mode exception codes are named, interrupts are not modelled */
`default_nettype none

package riscv_pkg;

    // register file address width, x0..x31
    localparam int REG_ADDR_W = 5;

    // trap code reported by the MEM stage
    typedef enum logic [4:0]
    {
        EXC_INSTR_MISALIGN = 5'd0,
        EXC_INSTR_FAULT    = 5'd1,
        EXC_ILLEGAL_INSTR  = 5'd2,
        EXC_BREAKPOINT     = 5'd3,
        EXC_LOAD_MISALIGN  = 5'd4,
        EXC_LOAD_FAULT     = 5'd5,
        EXC_STORE_MISALIGN = 5'd6,
        EXC_STORE_FAULT    = 5'd7,
        EXC_ECALL_U        = 5'd8,
        EXC_ECALL_S        = 5'd9,
        EXC_ECALL_M        = 5'd11,
        EXC_INSTR_PAGE     = 5'd12,
        EXC_LOAD_PAGE      = 5'd13,
        EXC_STORE_PAGE     = 5'd15,
        // no trap in MEM this cycle
        NO_TRAP            = 5'd16,
        // return from machine mode handler
        MRET               = 5'd17
    } exc_t;

    // next pc source for fetch
    typedef enum logic [1:0]
    {
        PC_JUMP = 2'd0,
        PC_MEPC = 2'd1,
        PC_EXC  = 2'd2
    } pc_sel_t;

    // mcause CSR word, seen raw by the CSR file or by field when it is built
    typedef union packed
    {
        logic [31:0] raw;
        struct packed
        {
            logic        irq;
            logic [26:0] zero;
            logic [3:0]  code;
        } field;
    } mcause_u;

endpackage

`default_nettype wire

// File: verilog/pipe_tracker.sv
/* destination tags of ID/EX, EX/MEM and MEM/WB; a load tag marks a load writing a nonzero rd
   write enables are masked for x0 on entry, so no consumer has to compare against x0 */
`default_nettype none

module pipe_tracker
(
    input  wire                              clk_i,
    input  wire                              rst_n_i,

    // instruction in ID
    input  wire                              id_valid_i,
    input  wire [riscv_pkg::REG_ADDR_W-1:0]  id_rd_addr_i,
    input  wire                              id_write_rd_i,
    input  wire                              id_use_mem_i,
    input  wire                              id_is_csr_i,

    // bubble requests from the hazard controller
    input  wire                              id_ex_flush_i,
    input  wire                              ex_mem_flush_i,
    input  wire riscv_pkg::exc_t             mem_trap_i,

    // ID/EX tags
    output logic [riscv_pkg::REG_ADDR_W-1:0] id_ex_rd_o,
    output logic                             id_ex_load_o,
    output logic                             id_ex_csr_o,

    // EX/MEM tags
    output logic [riscv_pkg::REG_ADDR_W-1:0] ex_mem_rd_o,
    output logic                             ex_mem_write_o,
    output logic                             ex_mem_load_o,
    output logic                             ex_mem_csr_o,

    // MEM/WB tags
    output logic [riscv_pkg::REG_ADDR_W-1:0] mem_wb_rd_o,
    output logic                             mem_wb_write_o,
    output logic                             mem_wb_load_o
);

    // write enable of ID/EX, kept internal since only later stages forward
    logic id_ex_write_q;
    logic id_write;
    logic id_load;
    logic mem_trap;

    // x0 is hardwired, so a write to it is dropped right here
    assign id_write = id_write_rd_i && (id_rd_addr_i != '0);
    // a store uses memory too but writes no rd, so it is never a load here
    assign id_load  = id_write && id_use_mem_i;
    // MRET also counts, the MEM instruction never retires through WB
    assign mem_trap = (mem_trap_i != riscv_pkg::NO_TRAP);

    // ID/EX takes the ID tags, bubble on flush or an empty ID slot
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            id_ex_rd_o    <= '0;
            id_ex_write_q <= 1'b0;
            id_ex_load_o  <= 1'b0;
            id_ex_csr_o   <= 1'b0;
        end
        else if (id_ex_flush_i || !id_valid_i)
        begin
            id_ex_rd_o    <= '0;
            id_ex_write_q <= 1'b0;
            id_ex_load_o  <= 1'b0;
            id_ex_csr_o   <= 1'b0;
        end
        else
        begin
            id_ex_rd_o    <= id_rd_addr_i;
            id_ex_write_q <= id_write;
            id_ex_load_o  <= id_load;
            id_ex_csr_o   <= id_is_csr_i;
        end
    end

    // EX/MEM follows ID/EX, bubble when a trap kills it
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            ex_mem_rd_o    <= '0;
            ex_mem_write_o <= 1'b0;
            ex_mem_load_o  <= 1'b0;
            ex_mem_csr_o   <= 1'b0;
        end
        else if (ex_mem_flush_i)
        begin
            ex_mem_rd_o    <= '0;
            ex_mem_write_o <= 1'b0;
            ex_mem_load_o  <= 1'b0;
            ex_mem_csr_o   <= 1'b0;
        end
        else
        begin
            ex_mem_rd_o    <= id_ex_rd_o;
            ex_mem_write_o <= id_ex_write_q;
            ex_mem_load_o  <= id_ex_load_o;
            ex_mem_csr_o   <= id_ex_csr_o;
        end
    end

    // MEM/WB follows EX/MEM, the trapping instruction becomes a bubble
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            mem_wb_rd_o    <= '0;
            mem_wb_write_o <= 1'b0;
            mem_wb_load_o  <= 1'b0;
        end
        else if (mem_trap)
        begin
            mem_wb_rd_o    <= '0;
            mem_wb_write_o <= 1'b0;
            mem_wb_load_o  <= 1'b0;
        end
        else
        begin
            mem_wb_rd_o    <= ex_mem_rd_o;
            mem_wb_write_o <= ex_mem_write_o;
            mem_wb_load_o  <= ex_mem_load_o;
        end
    end

    // masking happens once at ID, every later stage has to keep it through the shifts
    x0_never_written: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !((id_ex_write_q && (id_ex_rd_o == '0)) ||
          (ex_mem_write_o && (ex_mem_rd_o == '0)) ||
          (mem_wb_write_o && (mem_wb_rd_o == '0))));

endmodule

`default_nettype wire

// File: verilog/operand_forward.sv
/* one source operand of the EX instruction; write tags must already be masked for x0
   an EX/MEM load never forwards, the load-use stall covers that case */
`default_nettype none

module operand_forward
#(
    parameter int XLEN = 32
)
(
    // source addresses in ID and EX
    input  wire [riscv_pkg::REG_ADDR_W-1:0] id_rs_i,
    input  wire [riscv_pkg::REG_ADDR_W-1:0] ex_rs_i,
    input  wire [XLEN-1:0]                  rs_rdata_i,

    // ID/EX tags, for load-use only
    input  wire [riscv_pkg::REG_ADDR_W-1:0] id_ex_rd_i,
    input  wire                             id_ex_load_i,

    // EX/MEM tags and result
    input  wire [riscv_pkg::REG_ADDR_W-1:0] ex_mem_rd_i,
    input  wire                             ex_mem_write_i,
    input  wire                             ex_mem_load_i,
    input  wire [XLEN-1:0]                  ex_mem_alu_i,

    // MEM/WB tags and results
    input  wire [riscv_pkg::REG_ADDR_W-1:0] mem_wb_rd_i,
    input  wire                             mem_wb_write_i,
    input  wire                             mem_wb_load_i,
    input  wire [XLEN-1:0]                  mem_wb_alu_i,
    input  wire [XLEN-1:0]                  mem_wb_rdata_i,

    output logic                            fwd_ex_mem_o,
    output logic                            fwd_mem_wb_o,
    output logic [XLEN-1:0]                 operand_o,
    output logic                            load_use_o
);

    logic ex_mem_hit;
    logic mem_wb_hit;

    // the alu result of a load is its address, not the data
    assign ex_mem_hit = ex_mem_write_i && !ex_mem_load_i && (ex_mem_rd_i == ex_rs_i);
    assign mem_wb_hit = mem_wb_write_i && (mem_wb_rd_i == ex_rs_i);

    // the younger writer holds the newer value of rd
    assign fwd_ex_mem_o = ex_mem_hit;
    assign fwd_mem_wb_o = mem_wb_hit && !ex_mem_hit;

    always_comb
    begin
        if (fwd_ex_mem_o)
            operand_o = ex_mem_alu_i;
        else if (fwd_mem_wb_o)
            // loaded data for a load, alu result for anything else
            operand_o = mem_wb_load_i ? mem_wb_rdata_i : mem_wb_alu_i;
        else
            operand_o = rs_rdata_i;
    end

    // load in ID/EX feeding the ID instruction, data is one cycle late
    assign load_use_o = id_ex_load_i && (id_ex_rd_i == id_rs_i);

    // at most one forwarding path drives the EX operand
    fwd_onehot: assert final (!(fwd_ex_mem_o && fwd_mem_wb_o));

endmodule

`default_nettype wire

// File: verilog/hazard_ctrl.sv
/* stalls hold IF/ID for one cycle only; MRET and traps are taken from the MEM stage
   mcause is always a synchronous exception, irq stays zero */
`default_nettype none

module hazard_ctrl
#(
    parameter int NUM_SRC = 2
)
(
    // one load-use match per ID source
    input  wire [NUM_SRC-1:0]       load_use_i,

    input  wire                     id_valid_i,
    input  wire                     id_is_csr_i,
    input  wire                     id_ex_csr_i,
    input  wire                     ex_mem_csr_i,

    // taken branch or jump resolved in EX
    input  wire                     ex_new_pc_en_i,
    input  wire riscv_pkg::exc_t    mem_trap_i,

    // pipeline register controls
    output logic                    if_id_stall_o,
    output logic                    if_id_flush_o,
    output logic                    id_ex_flush_o,
    output logic                    ex_mem_flush_o,

    // fetch steering
    output logic                    new_pc_en_o,
    output riscv_pkg::pc_sel_t      pc_sel_o,

    // to the CSR file
    output logic                    csr_mret_o,
    output logic                    is_trap_o,
    output riscv_pkg::mcause_u      csr_mcause_o
);

    logic load_use;
    logic mem_trap;
    logic csr_in_flight;

    assign load_use      = |load_use_i;
    assign mem_trap      = (mem_trap_i != riscv_pkg::NO_TRAP);
    // CSR side effects land late, so younger instructions wait
    assign csr_in_flight = id_ex_csr_i || ex_mem_csr_i;

    // hold the ID instruction while its load or a CSR is ahead
    assign if_id_stall_o  = load_use || csr_in_flight;
    // nothing behind a CSR enters ID until it drains
    assign if_id_flush_o  = id_is_csr_i || csr_in_flight;
    // bubble into EX on redirect, empty ID, load-use or trap
    assign id_ex_flush_o  = ex_new_pc_en_i || !id_valid_i || load_use || mem_trap;
    // a trap in MEM also kills the EX instruction
    assign ex_mem_flush_o = mem_trap;

    // MEM outranks EX, it is the older instruction
    always_comb
    begin
        new_pc_en_o = 1'b0;
        pc_sel_o    = riscv_pkg::PC_JUMP;
        csr_mret_o  = 1'b0;
        is_trap_o   = 1'b0;
        unique case (mem_trap_i)
            riscv_pkg::NO_TRAP:
            begin
                new_pc_en_o = ex_new_pc_en_i;
                pc_sel_o    = riscv_pkg::PC_JUMP;
            end
            riscv_pkg::MRET:
            begin
                new_pc_en_o = 1'b1;
                pc_sel_o    = riscv_pkg::PC_MEPC;
                csr_mret_o  = 1'b1;
            end
            default:
            begin
                // any exception code, vector to the handler
                new_pc_en_o = 1'b1;
                pc_sel_o    = riscv_pkg::PC_EXC;
                is_trap_o   = 1'b1;
            end
        endcase
    end

    // cause code is the low nibble of the trap code
    always_comb
    begin
        csr_mcause_o            = '0;
        csr_mcause_o.field.irq  = 1'b0;
        csr_mcause_o.field.code = mem_trap_i[3:0];
    end

    // the CSR file would update mstatus twice otherwise
    mret_trap_excl: assert final (!(csr_mret_o && is_trap_o));

endmodule

`default_nettype wire

// File: verilog/pipe_ctrl_top.sv
/* stage data inputs must line up with the tracked ID/EX, EX/MEM and MEM/WB tags
   NUM_SRC may be 1 to 3; no back-pressure, id_valid_i is the only strobe */
`default_nettype none

module pipe_ctrl_top
#(
    parameter int XLEN    = 32,
    parameter int NUM_SRC = 2
)
(
    input  wire                                           clk_i,
    input  wire                                           rst_n_i,

    // ID stage
    input  wire                                           id_valid_i,
    input  wire [NUM_SRC-1:0][riscv_pkg::REG_ADDR_W-1:0]  id_rs_addr_i,
    input  wire [riscv_pkg::REG_ADDR_W-1:0]               id_rd_addr_i,
    input  wire                                           id_write_rd_i,
    input  wire                                           id_use_mem_i,
    input  wire                                           id_is_csr_i,

    // EX stage
    input  wire [NUM_SRC-1:0][riscv_pkg::REG_ADDR_W-1:0]  ex_rs_addr_i,
    input  wire [NUM_SRC-1:0][XLEN-1:0]                   ex_rs_rdata_i,
    input  wire                                           ex_new_pc_en_i,

    // later stage data and MEM trap
    input  wire [XLEN-1:0]                                ex_mem_alu_result_i,
    input  wire [XLEN-1:0]                                mem_wb_alu_result_i,
    input  wire [XLEN-1:0]                                mem_wb_dmem_rdata_i,
    input  wire riscv_pkg::exc_t                          mem_trap_i,

    // per operand forwarding
    output logic [NUM_SRC-1:0]                            fwd_ex_mem_o,
    output logic [NUM_SRC-1:0]                            fwd_mem_wb_o,
    output logic [NUM_SRC-1:0][XLEN-1:0]                  ex_operand_o,

    // pipeline controls and steering
    output logic                                          if_id_stall_o,
    output logic                                          if_id_flush_o,
    output logic                                          id_ex_flush_o,
    output logic                                          ex_mem_flush_o,
    output logic                                          new_pc_en_o,
    output riscv_pkg::pc_sel_t                            pc_sel_o,
    output logic                                          csr_mret_o,
    output logic                                          is_trap_o,
    output riscv_pkg::mcause_u                            csr_mcause_o
);

    // tracker tags
    logic [riscv_pkg::REG_ADDR_W-1:0] id_ex_rd;
    logic                             id_ex_load;
    logic                             id_ex_csr;
    logic [riscv_pkg::REG_ADDR_W-1:0] ex_mem_rd;
    logic                             ex_mem_write;
    logic                             ex_mem_load;
    logic                             ex_mem_csr;
    logic [riscv_pkg::REG_ADDR_W-1:0] mem_wb_rd;
    logic                             mem_wb_write;
    logic                             mem_wb_load;
    // load-use match per ID source
    logic [NUM_SRC-1:0]               load_use;

    pipe_tracker u_tracker
    (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .id_valid_i     (id_valid_i),
        .id_rd_addr_i   (id_rd_addr_i),
        .id_write_rd_i  (id_write_rd_i),
        .id_use_mem_i   (id_use_mem_i),
        .id_is_csr_i    (id_is_csr_i),
        .id_ex_flush_i  (id_ex_flush_o),
        .ex_mem_flush_i (ex_mem_flush_o),
        .mem_trap_i     (mem_trap_i),
        .id_ex_rd_o     (id_ex_rd),
        .id_ex_load_o   (id_ex_load),
        .id_ex_csr_o    (id_ex_csr),
        .ex_mem_rd_o    (ex_mem_rd),
        .ex_mem_write_o (ex_mem_write),
        .ex_mem_load_o  (ex_mem_load),
        .ex_mem_csr_o   (ex_mem_csr),
        .mem_wb_rd_o    (mem_wb_rd),
        .mem_wb_write_o (mem_wb_write),
        .mem_wb_load_o  (mem_wb_load)
    );

    // one forwarding unit per source operand slot
    for (genvar s = 0; s < NUM_SRC; s++)
    begin : g_src
        operand_forward #(.XLEN(XLEN)) u_fwd
        (
            .id_rs_i        (id_rs_addr_i[s]),
            .ex_rs_i        (ex_rs_addr_i[s]),
            .rs_rdata_i     (ex_rs_rdata_i[s]),
            .id_ex_rd_i     (id_ex_rd),
            .id_ex_load_i   (id_ex_load),
            .ex_mem_rd_i    (ex_mem_rd),
            .ex_mem_write_i (ex_mem_write),
            .ex_mem_load_i  (ex_mem_load),
            .ex_mem_alu_i   (ex_mem_alu_result_i),
            .mem_wb_rd_i    (mem_wb_rd),
            .mem_wb_write_i (mem_wb_write),
            .mem_wb_load_i  (mem_wb_load),
            .mem_wb_alu_i   (mem_wb_alu_result_i),
            .mem_wb_rdata_i (mem_wb_dmem_rdata_i),
            .fwd_ex_mem_o   (fwd_ex_mem_o[s]),
            .fwd_mem_wb_o   (fwd_mem_wb_o[s]),
            .operand_o      (ex_operand_o[s]),
            .load_use_o     (load_use[s])
        );
    end

    hazard_ctrl #(.NUM_SRC(NUM_SRC)) u_hazard
    (
        .load_use_i     (load_use),
        .id_valid_i     (id_valid_i),
        .id_is_csr_i    (id_is_csr_i),
        .id_ex_csr_i    (id_ex_csr),
        .ex_mem_csr_i   (ex_mem_csr),
        .ex_new_pc_en_i (ex_new_pc_en_i),
        .mem_trap_i     (mem_trap_i),
        .if_id_stall_o  (if_id_stall_o),
        .if_id_flush_o  (if_id_flush_o),
        .id_ex_flush_o  (id_ex_flush_o),
        .ex_mem_flush_o (ex_mem_flush_o),
        .new_pc_en_o    (new_pc_en_o),
        .pc_sel_o       (pc_sel_o),
        .csr_mret_o     (csr_mret_o),
        .is_trap_o      (is_trap_o),
        .csr_mcause_o   (csr_mcause_o)
    );

endmodule

`default_nettype wire

// File: test/clk_gen.sv
/* free running testbench clock, first rising edge half a period after time zero */
`default_nettype none

module clk_gen
#(
    parameter int PERIOD = 4
)
(
    output logic clk_o
);

    // toggle every half period
    initial
    begin
        clk_o = 1'b0;
        forever
        begin
            #(PERIOD / 2);
            clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// File: test/tb_pipe_ctrl.sv
/* random pipeline traffic checked against a stage model; source registers stay within x0..x7
   so that hazards are frequent; stage data is random and not tied to any real datapath */
`default_nettype none

module tb_pipe_ctrl;

    localparam int XLEN         = 32;
    localparam int NUM_SRC      = 2;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int AW           = riscv_pkg::REG_ADDR_W;
    // four phases, each ending with one idle edge
    localparam int TEST_CYCLES  = 8 + 800 + 400 + 800 + 4;
    localparam int WATCHDOG     = (RESET_CYCLES + TEST_CYCLES) * CLK_PERIOD * 2;

    logic                          clk;
    logic                          rst_n_i;
    logic                          id_valid_i;
    logic [NUM_SRC-1:0][AW-1:0]    id_rs_addr_i;
    logic [AW-1:0]                 id_rd_addr_i;
    logic                          id_write_rd_i;
    logic                          id_use_mem_i;
    logic                          id_is_csr_i;
    logic [NUM_SRC-1:0][AW-1:0]    ex_rs_addr_i;
    logic [NUM_SRC-1:0][XLEN-1:0]  ex_rs_rdata_i;
    logic                          ex_new_pc_en_i;
    logic [XLEN-1:0]               ex_mem_alu_result_i;
    logic [XLEN-1:0]               mem_wb_alu_result_i;
    logic [XLEN-1:0]               mem_wb_dmem_rdata_i;
    riscv_pkg::exc_t               mem_trap_i;

    logic [NUM_SRC-1:0]            fwd_ex_mem_o;
    logic [NUM_SRC-1:0]            fwd_mem_wb_o;
    logic [NUM_SRC-1:0][XLEN-1:0]  ex_operand_o;
    logic                          if_id_stall_o;
    logic                          if_id_flush_o;
    logic                          id_ex_flush_o;
    logic                          ex_mem_flush_o;
    logic                          new_pc_en_o;
    riscv_pkg::pc_sel_t            pc_sel_o;
    logic                          csr_mret_o;
    logic                          is_trap_o;
    riscv_pkg::mcause_u            csr_mcause_o;

    // model copy of the three tracked stages
    logic [AW-1:0] m_idex_rd;
    logic          m_idex_write;
    logic          m_idex_load;
    logic          m_idex_csr;
    logic [AW-1:0] m_exmem_rd;
    logic          m_exmem_write;
    logic          m_exmem_load;
    logic          m_exmem_csr;
    logic [AW-1:0] m_memwb_rd;
    logic          m_memwb_write;
    logic          m_memwb_load;

    logic [31:0]   rng_state;
    string         test_name;
    bit            running;
    int            total_checks;
    int            total_errors;
    int            phase_checks;
    int            phase_errors;
    int            cycles_after_reset;

    // expected control values of the current cycle
    logic               lu_exp;
    logic               trap_exp;
    logic               csr_busy_exp;
    logic               idex_flush_exp;
    logic               pc_en_exp;
    logic               mret_exp;
    logic               is_trap_exp;
    riscv_pkg::pc_sel_t sel_exp;

    clk_gen #(.PERIOD(CLK_PERIOD)) u_clk
    (
        .clk_o (clk)
    );

    pipe_ctrl_top #(.XLEN(XLEN), .NUM_SRC(NUM_SRC)) uut
    (
        .clk_i               (clk),
        .rst_n_i             (rst_n_i),
        .id_valid_i          (id_valid_i),
        .id_rs_addr_i        (id_rs_addr_i),
        .id_rd_addr_i        (id_rd_addr_i),
        .id_write_rd_i       (id_write_rd_i),
        .id_use_mem_i        (id_use_mem_i),
        .id_is_csr_i         (id_is_csr_i),
        .ex_rs_addr_i        (ex_rs_addr_i),
        .ex_rs_rdata_i       (ex_rs_rdata_i),
        .ex_new_pc_en_i      (ex_new_pc_en_i),
        .ex_mem_alu_result_i (ex_mem_alu_result_i),
        .mem_wb_alu_result_i (mem_wb_alu_result_i),
        .mem_wb_dmem_rdata_i (mem_wb_dmem_rdata_i),
        .mem_trap_i          (mem_trap_i),
        .fwd_ex_mem_o        (fwd_ex_mem_o),
        .fwd_mem_wb_o        (fwd_mem_wb_o),
        .ex_operand_o        (ex_operand_o),
        .if_id_stall_o       (if_id_stall_o),
        .if_id_flush_o       (if_id_flush_o),
        .id_ex_flush_o       (id_ex_flush_o),
        .ex_mem_flush_o      (ex_mem_flush_o),
        .new_pc_en_o         (new_pc_en_o),
        .pc_sel_o            (pc_sel_o),
        .csr_mret_o          (csr_mret_o),
        .is_trap_o           (is_trap_o),
        .csr_mcause_o        (csr_mcause_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic draw(output logic [31:0] v);
        rng_state = xorshift32(rng_state);
        v = rng_state;
    endtask

    // named exception codes, MRET twice as often as any one of them
    function automatic riscv_pkg::exc_t trap_code(input logic [3:0] k);
        case (k)
            4'd10:   return riscv_pkg::EXC_ECALL_M;
            4'd14:   return riscv_pkg::MRET;
            4'd15:   return riscv_pkg::MRET;
            4'd11:   return riscv_pkg::EXC_INSTR_PAGE;
            4'd12:   return riscv_pkg::EXC_LOAD_PAGE;
            4'd13:   return riscv_pkg::EXC_STORE_PAGE;
            default: return riscv_pkg::exc_t'({1'b0, k});
        endcase
    endfunction

    // newest non-load writer of rs in EX/MEM wins
    function automatic logic exp_ex_mem_fwd(input logic [AW-1:0] rs);
        return m_exmem_write && !m_exmem_load && (m_exmem_rd == rs);
    endfunction

    function automatic logic exp_mem_wb_fwd(input logic [AW-1:0] rs);
        return m_memwb_write && (m_memwb_rd == rs) && !exp_ex_mem_fwd(rs);
    endfunction

    function automatic logic [XLEN-1:0] exp_operand(input int s);
        if (exp_ex_mem_fwd(ex_rs_addr_i[s]))
            return ex_mem_alu_result_i;
        if (exp_mem_wb_fwd(ex_rs_addr_i[s]))
            return m_memwb_load ? mem_wb_dmem_rdata_i : mem_wb_alu_result_i;
        return ex_rs_rdata_i[s];
    endfunction

    // load in ID/EX feeding either ID source
    function automatic logic exp_load_use();
        logic hit;
        hit = 1'b0;
        for (int s = 0; s < NUM_SRC; s++)
            hit = hit | (m_idex_load && (m_idex_rd == id_rs_addr_i[s]));
        return hit;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        total_checks++;
        phase_checks++;
        if (actual !== expected)
        begin
            total_errors++;
            phase_errors++;
            $display("Mismatch in %s, %s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    // one cycle of random ID, EX and stage inputs
    task automatic drive_cycle(input bit allow_csr, input bit allow_pc);
        logic [31:0] r;
        logic [31:0] d;
        draw(r);
        id_valid_i    <= (r[3:0] != 4'd0);
        id_rd_addr_i  <= {2'b00, r[12:10]};
        id_write_rd_i <= r[13] | r[14];
        id_use_mem_i  <= (r[16:15] == 2'd0);
        id_is_csr_i   <= allow_csr && (r[19:17] == 3'd0);
        ex_new_pc_en_i <= allow_pc && (r[28:26] == 3'd0);
        for (int s = 0; s < NUM_SRC; s++)
        begin
            id_rs_addr_i[s] <= {2'b00, 3'(r >> (4 + 3 * s))};
            ex_rs_addr_i[s] <= {2'b00, 3'(r >> (20 + 3 * s))};
            draw(d);
            ex_rs_rdata_i[s] <= d;
        end
        draw(d);
        ex_mem_alu_result_i <= d;
        draw(d);
        mem_wb_alu_result_i <= d;
        draw(d);
        mem_wb_dmem_rdata_i <= d;
        draw(d);
        if (allow_pc && (r[31:29] == 3'd0))
            mem_trap_i <= trap_code(d[3:0]);
        else
            mem_trap_i <= riscv_pkg::NO_TRAP;
    endtask

    task automatic run_phase(input string name, input int cycles,
                             input bit allow_csr, input bit allow_pc);
        test_name    = name;
        phase_checks = 0;
        phase_errors = 0;
        running      = 1'b1;
        repeat (cycles)
        begin
            @(posedge clk);
            drive_cycle(allow_csr, allow_pc);
        end
        // the last inputs are compared one step after this edge
        @(posedge clk);
        $display("test %s finished: %0d checks, %0d mismatches",
                 name, phase_checks, phase_errors);
    endtask

    // stimulus
    initial
    begin
        rng_state           = 32'h7029;
        running             = 1'b0;
        total_checks        = 0;
        total_errors        = 0;
        cycles_after_reset  = 0;
        test_name           = "reset";
        rst_n_i             <= 1'b0;
        id_valid_i          <= 1'b0;
        id_rs_addr_i        <= '0;
        id_rd_addr_i        <= '0;
        id_write_rd_i       <= 1'b0;
        id_use_mem_i        <= 1'b0;
        id_is_csr_i         <= 1'b0;
        ex_rs_addr_i        <= '0;
        ex_rs_rdata_i       <= '0;
        ex_new_pc_en_i      <= 1'b0;
        ex_mem_alu_result_i <= '0;
        mem_wb_alu_result_i <= '0;
        mem_wb_dmem_rdata_i <= '0;
        mem_trap_i          <= riscv_pkg::NO_TRAP;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        run_phase("after_reset", 8, 1'b0, 1'b0);
        run_phase("forward_mix", 800, 1'b0, 1'b0);
        run_phase("csr_serial", 400, 1'b1, 1'b0);
        run_phase("pc_steer", 800, 1'b1, 1'b1);
        running = 1'b0;
        #(CLK_PERIOD / 2);
        $display("total: %0d checks, %0d mismatches", total_checks, total_errors);
        if (total_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // compare, then advance the stage model with the inputs of this cycle
    initial
    begin
        m_idex_rd     = '0;
        m_idex_write  = 1'b0;
        m_idex_load   = 1'b0;
        m_idex_csr    = 1'b0;
        m_exmem_rd    = '0;
        m_exmem_write = 1'b0;
        m_exmem_load  = 1'b0;
        m_exmem_csr   = 1'b0;
        m_memwb_rd    = '0;
        m_memwb_write = 1'b0;
        m_memwb_load  = 1'b0;
        forever
        begin
            @(posedge clk);
            #1;
            if (rst_n_i && running)
            begin
                lu_exp         = exp_load_use();
                trap_exp       = (mem_trap_i != riscv_pkg::NO_TRAP);
                csr_busy_exp   = m_idex_csr || m_exmem_csr;
                idex_flush_exp = ex_new_pc_en_i || !id_valid_i || lu_exp || trap_exp;
                for (int s = 0; s < NUM_SRC; s++)
                begin
                    check_value("fwd_ex_mem", 32'(exp_ex_mem_fwd(ex_rs_addr_i[s])),
                                32'(fwd_ex_mem_o[s]));
                    check_value("fwd_mem_wb", 32'(exp_mem_wb_fwd(ex_rs_addr_i[s])),
                                32'(fwd_mem_wb_o[s]));
                    check_value("ex_operand", exp_operand(s), ex_operand_o[s]);
                end
                check_value("if_id_stall", 32'(lu_exp || csr_busy_exp), 32'(if_id_stall_o));
                check_value("if_id_flush", 32'(id_is_csr_i || csr_busy_exp),
                            32'(if_id_flush_o));
                check_value("id_ex_flush", 32'(idex_flush_exp), 32'(id_ex_flush_o));
                check_value("ex_mem_flush", 32'(trap_exp), 32'(ex_mem_flush_o));

                // MEM is older than EX, so its trap or MRET wins
                mret_exp    = (mem_trap_i == riscv_pkg::MRET);
                is_trap_exp = trap_exp && !mret_exp;
                pc_en_exp   = trap_exp || ex_new_pc_en_i;
                if (mret_exp)
                    sel_exp = riscv_pkg::PC_MEPC;
                else if (is_trap_exp)
                    sel_exp = riscv_pkg::PC_EXC;
                else
                    sel_exp = riscv_pkg::PC_JUMP;
                check_value("new_pc_en", 32'(pc_en_exp), 32'(new_pc_en_o));
                check_value("csr_mret", 32'(mret_exp), 32'(csr_mret_o));
                check_value("is_trap", 32'(is_trap_exp), 32'(is_trap_o));
                if (pc_en_exp)
                    check_value("pc_sel", 32'(sel_exp), 32'(pc_sel_o));
                // exception codes are below 16, so the cause word is the code itself
                if (is_trap_exp)
                    check_value("mcause", 32'(mem_trap_i), csr_mcause_o.raw);

                // first edge out of reset samples idle inputs, so two cycles see only bubbles
                if (cycles_after_reset < 2)
                begin
                    check_value("fwd after reset", 32'd0, 32'({fwd_ex_mem_o, fwd_mem_wb_o}));
                    check_value("stall after reset", 32'd0, 32'(if_id_stall_o));
                end
                cycles_after_reset++;

                // shift oldest first so each stage reads its old neighbour
                if (trap_exp)
                begin
                    m_memwb_rd    = '0;
                    m_memwb_write = 1'b0;
                    m_memwb_load  = 1'b0;
                end
                else
                begin
                    m_memwb_rd    = m_exmem_rd;
                    m_memwb_write = m_exmem_write;
                    m_memwb_load  = m_exmem_load;
                end
                if (trap_exp)
                begin
                    m_exmem_rd    = '0;
                    m_exmem_write = 1'b0;
                    m_exmem_load  = 1'b0;
                    m_exmem_csr   = 1'b0;
                end
                else
                begin
                    m_exmem_rd    = m_idex_rd;
                    m_exmem_write = m_idex_write;
                    m_exmem_load  = m_idex_load;
                    m_exmem_csr   = m_idex_csr;
                end
                if (idex_flush_exp)
                begin
                    m_idex_rd    = '0;
                    m_idex_write = 1'b0;
                    m_idex_load  = 1'b0;
                    m_idex_csr   = 1'b0;
                end
                else
                begin
                    // x0 is never a destination, a load is a memory op that writes rd
                    m_idex_rd    = id_rd_addr_i;
                    m_idex_write = id_write_rd_i && (id_rd_addr_i != '0);
                    m_idex_load  = id_write_rd_i && (id_rd_addr_i != '0) && id_use_mem_i;
                    m_idex_csr   = id_is_csr_i;
                end
            end
        end
    end

    // watchdog, twice the expected run length
    initial
    begin
        #(WATCHDOG);
        $display("watchdog expired: the test sequence did not finish in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
verilog/riscv_pkg.sv
verilog/pipe_tracker.sv
verilog/operand_forward.sv
verilog/hazard_ctrl.sv
verilog/pipe_ctrl_top.sv
test/clk_gen.sv
test/tb_pipe_ctrl.sv

// File: Makefile
TOP = tb_pipe_ctrl

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f src.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'Simulation passed'

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)
	verilator --lint-only -Wall verilog/riscv_pkg.sv verilog/pipe_tracker.sv \
		verilog/operand_forward.sv verilog/hazard_ctrl.sv verilog/pipe_ctrl_top.sv \
		--top-module pipe_ctrl_top

clean:
	rm -rf obj_dir
